// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the golden dinners, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dining_table -f verilog.f
	./obj_dir/Vtb_dining_table +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: design/dining_table.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module dining_table (
  input  logic                   clock,
  input  logic                   reset,
  input  dpp_pkg::dinner_cfg_t   cfg,
  input  logic                   cfg_req,
  output logic                   cfg_ack,
  output dpp_pkg::table_status_t status
);

  localparam int N = `DPP_N_PHILO;

  dpp_pkg::dinner_cfg_t              seat_cfg;  // latched dinner
  logic                              start;
  logic                              busy;
  logic [N-1:0]                      fork_req;
  logic [N-1:0]                      fork_ack;
  dpp_pkg::philo_state_e [N-1:0]     state;

  // decode, host handshake and config latch
  dinner_loader loader_i (
    .reset(reset), .clock(clock),
    .cfg(cfg), .cfg_req(cfg_req), .cfg_ack(cfg_ack),
    .busy(busy), .seat_cfg(seat_cfg), .start(start)
  );

  // execute, one seat per philosopher
  for (genvar i = 0; i < N; i++) begin : g_seat
    philosopher philo_i (
      .clock(clock), .reset(reset), .start(start),
      .cfg(seat_cfg[i]),
      .fork_req(fork_req[i]), .fork_ack(fork_ack[i]),
      .state(state[i])
    );
  end

  fork_arbiter arbiter_i (
    .clock(clock), .reset(reset),
    .fork_req(fork_req), .fork_ack(fork_ack)
  );

  // result, meal counts and done
  dinner_tally tally_i (
    .clock(clock), .reset(reset), .start(start),
    .state(state), .fork_ack(fork_ack),
    .status(status), .busy(busy)
  );

endmodule

// File: design/dinner_loader.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module dinner_loader (
  input  logic                 reset,
  input  logic                 clock,
  input  dpp_pkg::dinner_cfg_t cfg,
  input  logic                 cfg_req,
  output logic                 cfg_ack,
  input  logic                 busy,     // dinner running, hold off the host
  output dpp_pkg::dinner_cfg_t seat_cfg,
  output logic                 start
);

  dpp_pkg::loader_state_e state;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= dpp_pkg::idle;
    end else begin
      case (state)
        dpp_pkg::idle: if (cfg_req && !busy) state <= dpp_pkg::ack_high; // accept
        // host cannot have seen ack yet, but a short req still closes cleanly
        dpp_pkg::ack_high: state <= cfg_req ? dpp_pkg::wait_release : dpp_pkg::idle;
        dpp_pkg::wait_release: if (!cfg_req) state <= dpp_pkg::idle;
        default: state <= dpp_pkg::idle;
      endcase
    end
  end

  // payload latch, only moves on acceptance
  always_ff @(posedge clock) begin
    if (state == dpp_pkg::idle && cfg_req && !busy) seat_cfg <= cfg;
  end

  assign cfg_ack = (state != dpp_pkg::idle);   // high from accept until req falls
  assign start   = (state == dpp_pkg::ack_high); // one cycle, same as ack rise

endmodule

// File: design/dinner_tally.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module dinner_tally (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          start,
  input  dpp_pkg::philo_state_e [`DPP_N_PHILO-1:0]      state,
  input  logic [`DPP_N_PHILO-1:0]                       fork_ack,
  output dpp_pkg::table_status_t                        status,
  output logic                                          busy
);

  localparam int N  = `DPP_N_PHILO;
  localparam int CW = `DPP_CNT_W;

  logic [N-1:0]         ack_q;     // last ack, for edge detect
  logic [N-1:0][CW-1:0] meals;
  logic [N-1:0]         sated_vec;
  logic                 done;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      sated_vec[i]      = (state[i] == dpp_pkg::sated);
      status.eating[i]  = (state[i] == dpp_pkg::eating);
      status.meals[i]   = meals[i];
    end
    status.done = done;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q <= '0;
      meals <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      ack_q <= fork_ack;
      if (start) begin // new dinner, fresh counts
        meals <= '0;
        busy  <= 1'b1;
        done  <= 1'b0;
      end else begin
        for (int i = 0; i < N; i++)
          if (fork_ack[i] && !ack_q[i]) meals[i] <= meals[i] + 1'b1; // one meal per grant
        if (busy && (&sated_vec) && (fork_ack == '0)) begin
          done <= 1'b1; // held until next start
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

// File: design/dpp_defines.svh
`ifndef DPP_DEFINES_SVH
`define DPP_DEFINES_SVH

// table geometry, one fork between each pair of neighbours
`define DPP_N_PHILO 4 // seats, and forks too

// seat index width, enough to name any seat
`define DPP_SEAT_W 2

// quota, think time, eat time and meal counts
`define DPP_CNT_W 4

// the host payload is one seat config per seat,
// each made of three counter fields
`define DPP_SEAT_CFG_W (3 * `DPP_CNT_W)
`define DPP_DINNER_CFG_W (`DPP_N_PHILO * `DPP_SEAT_CFG_W)

`endif

// File: design/dpp_pkg.sv
`include "dpp_defines.svh"

package dpp_pkg;

  // life cycle of one seat
  typedef enum logic [1:0] {
    thinking = 2'd0,
    hungry   = 2'd1, // fork_req up, waiting for ack
    eating   = 2'd2, // holds both forks
    sated    = 2'd3  // quota reached, or idle between dinners
  } philo_state_e;

  // host handshake FSM in the loader
  typedef enum logic [1:0] {
    idle         = 2'd0,
    ack_high     = 2'd1, // accept cycle, start pulses here
    wait_release = 2'd2  // ack held until the host drops req
  } loader_state_e;

  typedef struct packed {
    logic [`DPP_CNT_W-1:0] quota;      // meals to eat, 0 means none
    logic [`DPP_CNT_W-1:0] think_time; // 0 treated as 1
    logic [`DPP_CNT_W-1:0] eat_time;   // 0 treated as 1
  } seat_cfg_t;

  typedef seat_cfg_t [`DPP_N_PHILO-1:0] dinner_cfg_t; // 48 bit payload

  typedef struct packed {
    logic [`DPP_N_PHILO-1:0]                eating;
    logic [`DPP_N_PHILO-1:0][`DPP_CNT_W-1:0] meals;
    logic                                   done;
  } table_status_t;

endpackage

// File: design/fork_arbiter.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module fork_arbiter (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`DPP_N_PHILO-1:0] fork_req,
  output logic [`DPP_N_PHILO-1:0] fork_ack
);

  localparam int N  = `DPP_N_PHILO;
  localparam int SW = `DPP_SEAT_W;

  // seat i eats with fork i and fork (i+1) mod N
  logic [N-1:0]         fork_held;  // fork is off the table
  logic [N-1:0][SW-1:0] fork_owner; // which seat holds it
  logic [SW-1:0]        ptr;        // rotating priority
  logic [N-1:0]         grant;
  logic [SW-1:0]        last_seat;  // last seat granted in the scan

  // scan from ptr, forks taken earlier in the scan count as held;
  // forks released this cycle only become free next cycle
  always_comb begin
    logic [N-1:0] fork_free;
    int seat;
    int right;
    fork_free = ~fork_held;
    grant     = '0;
    last_seat = ptr;
    for (int k = 0; k < N; k++) begin
      seat  = (int'(ptr) + k) % N;
      right = (seat + 1) % N;
      if (fork_req[seat] && !fork_ack[seat] && fork_free[seat] && fork_free[right]) begin
        grant[seat]      = 1'b1;
        fork_free[seat]  = 1'b0;
        fork_free[right] = 1'b0;
        last_seat        = SW'(seat);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      fork_held <= '0;
      fork_ack  <= '0;
      ptr       <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (fork_ack[i] && !fork_req[i]) begin // release phase
          fork_ack[i] <= 1'b0;
          if (fork_owner[i] == SW'(i)) fork_held[i] <= 1'b0;
          if (fork_owner[(i+1) % N] == SW'(i)) fork_held[(i+1) % N] <= 1'b0;
        end
      end
      // grants touch only free forks, so they never collide with releases
      for (int i = 0; i < N; i++) begin
        if (grant[i]) begin
          fork_ack[i]            <= 1'b1;
          fork_held[i]           <= 1'b1;
          fork_held[(i+1) % N]   <= 1'b1;
        end
      end
      if (|grant) ptr <= SW'((int'(last_seat) + 1) % N); // seat after last winner
    end
  end

  // owner table is payload, written with the grant
  always_ff @(posedge clock) begin
    for (int i = 0; i < N; i++) begin
      if (grant[i]) begin
        fork_owner[i]         <= SW'(i);
        fork_owner[(i+1) % N] <= SW'(i);
      end
    end
  end

endmodule

// File: design/philosopher.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module philosopher (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  dpp_pkg::seat_cfg_t    cfg,
  output logic                  fork_req,
  input  logic                  fork_ack,
  output dpp_pkg::philo_state_e state
);

  localparam int CW = `DPP_CNT_W;

  logic [CW-1:0] timer;      // think timer, then eat timer
  logic [CW-1:0] meals_left;
  logic [CW-1:0] think_load;
  logic [CW-1:0] eat_load;

  // zero times behave as one cycle
  assign think_load = (cfg.think_time == '0) ? CW'(1) : cfg.think_time;
  assign eat_load   = (cfg.eat_time == '0) ? CW'(1) : cfg.eat_time;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= dpp_pkg::sated; // parked until the first start
      fork_req   <= 1'b0;
      timer      <= '0;
      meals_left <= '0;
    end else if (start) begin
      meals_left <= cfg.quota;
      timer      <= think_load;
      state      <= (cfg.quota == '0) ? dpp_pkg::sated : dpp_pkg::thinking;
    end else begin
      case (state)
        dpp_pkg::thinking: begin
          if (timer <= CW'(1)) begin
            state    <= dpp_pkg::hungry;
            fork_req <= 1'b1; // ask for both forks
          end else begin
            timer <= timer - 1'b1;
          end
        end
        dpp_pkg::hungry: begin
          if (fork_ack) begin // ack rose last edge, that edge counts as cycle 1
            state      <= dpp_pkg::eating;
            meals_left <= meals_left - 1'b1;
            if (eat_load <= CW'(1)) fork_req <= 1'b0;
            else timer <= eat_load - 1'b1;
          end
        end
        dpp_pkg::eating: begin
          if (fork_req) begin
            if (timer <= CW'(1)) fork_req <= 1'b0; // done chewing, release
            else timer <= timer - 1'b1;
          end else if (!fork_ack) begin // forks back on the table
            if (meals_left == '0) begin
              state <= dpp_pkg::sated;
            end else begin
              state <= dpp_pkg::thinking;
              timer <= think_load;
            end
          end
        end
        default: ; // sated waits for the next start
      endcase
    end
  end

endmodule

// File: testbench/dpp_assert.sv
`timescale 1ns/1ps

module dpp_assert #(
  parameter int W = 1 // number of req/ack pairs watched
) (
  input logic         clock,
  input logic         reset,
  input logic [W-1:0] req,
  input logic [W-1:0] ack
);

  for (genvar i = 0; i < W; i++) begin : g_pair
    // ack only answers a request that is up
    assert property (@(posedge clock) disable iff (reset) $rose(ack[i]) |-> req[i])
      else $error("ack %0d rose with req low", i);
    // ack only drops once the request is gone
    assert property (@(posedge clock) disable iff (reset) $fell(ack[i]) |-> !req[i])
      else $error("ack %0d fell with req still high", i);
    assert property (@(posedge clock) disable iff (reset) req[i] && !ack[i] |=> req[i])
      else $error("req %0d withdrawn before ack", i); // no abandoned requests
    assert property (@(posedge clock) disable iff (reset) !req[i] && ack[i] |=> !req[i])
      else $error("req %0d raised again before ack fell", i);
  end

  // ring of seats, neighbours share a fork
  if (W > 1) begin : g_ring
    for (genvar i = 0; i < W; i++) begin : g_nb
      assert property (@(posedge clock) disable iff (reset) !(ack[i] && ack[(i + 1) % W]))
        else $error("neighbour seats %0d and %0d granted together", i, (i + 1) % W);
    end
  end

endmodule

// File: testbench/dpp_checker.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module dpp_checker (
  input  logic                                    clock,
  input  logic                                    reset,
  input  dpp_pkg::dinner_cfg_t                    cfg,
  input  logic                                    cfg_req,
  input  logic                                    cfg_ack,
  input  dpp_pkg::table_status_t                  status,
  input  logic [`DPP_N_PHILO-1:0][`DPP_CNT_W-1:0] exp_meals, // golden counts offered with cfg
  output int                                      error_count,
  output int                                      dinner_count
);

  localparam int N = `DPP_N_PHILO;

  dpp_pkg::dinner_cfg_t             cur_cfg; // dinner on the table
  logic [N-1:0][`DPP_CNT_W-1:0]     cur_exp;
  logic                             ack_q;
  logic                             done_q;
  logic                             running;   // between accept and done
  logic                             clear_due; // counts must read zero next sample
  int                               ack_wait;  // samples a req waited on an idle table

  task automatic flag_error(input string msg);
    $display("error %0t: %s", $time, msg);
    error_count++;
  endtask

  // sample mid-cycle, all DUT outputs settled
  always @(negedge clock) begin
    if (reset) begin
      error_count  = 0;
      dinner_count = 0;
      ack_q        = 1'b0;
      done_q       = 1'b0;
      running      = 1'b0;
      clear_due    = 1'b0;
      ack_wait     = 0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (status.eating[i] && status.eating[(i + 1) % N])
          flag_error($sformatf("seats %0d and %0d eat together", i, (i + 1) % N));
        if (running && cur_cfg[i].quota == '0 && status.eating[i])
          flag_error($sformatf("seat %0d eats with quota 0", i));
      end
      if (clear_due && status.meals != '0)
        flag_error($sformatf("meal counts %h not cleared on start", status.meals));
      clear_due = 1'b0;
      if (status.done && !done_q) begin // end of a dinner
        dinner_count++;
        running = 1'b0;
        for (int i = 0; i < N; i++)
          if (status.meals[i] != cur_exp[i])
            flag_error($sformatf("seat %0d ate %0d meals, expected %0d",
                                 i, status.meals[i], cur_exp[i]));
      end
      if (cfg_ack && !ack_q) begin // host config accepted
        if (!cfg_req) flag_error("cfg_ack rose with cfg_req low");
        if (running) flag_error("cfg_ack rose while a dinner was running");
        running   = 1'b1;
        cur_cfg   = cfg;
        cur_exp   = exp_meals;
        clear_due = 1'b1;
      end
      if (!cfg_ack && ack_q && cfg_req) flag_error("cfg_ack fell with cfg_req still high");
      // idle table answers within one cycle of seeing req
      ack_wait = (!running && cfg_req && !cfg_ack) ? ack_wait + 1 : 0;
      if (ack_wait == 2) flag_error("cfg_req on an idle table not acknowledged in time");
      ack_q  = cfg_ack;
      done_q = status.done;
    end
  end

endmodule

// File: testbench/dpp_golden.txt
// cfg hex, seat 3 down to seat 0, three nibbles each: quota think eat
// then expected meals for seat 3 2 1 0, then 1 to offer the next dinner mid-dinner
212212212212 2 2 2 2 0
323111055232 3 1 0 2 1
100100100100 1 1 1 1 0
011022033044 0 0 0 0 0
523523523523 5 5 5 5 1
411000411274 4 0 4 2 0
6f12f31f10f4 6 2 1 0 0

// File: testbench/tb_dining_table.sv
`timescale 1ns/1ps
`include "dpp_defines.svh"

module tb_dining_table;

  localparam int N  = `DPP_N_PHILO;
  localparam int CW = `DPP_CNT_W;

  logic                   clock;
  logic                   reset;
  dpp_pkg::dinner_cfg_t   cfg;
  logic                   cfg_req;
  logic                   cfg_ack;
  dpp_pkg::table_status_t status;
  logic [N-1:0][CW-1:0]   exp_meals; // travels with cfg to the checker
  int                     error_count;
  int                     dinner_count;
  int                     cycle_count = 0;
  int                     cycle_limit = 0;

  logic [`DPP_DINNER_CFG_W-1:0] cfg_q[$]; // one entry per golden line
  logic [N*CW-1:0]              exp_q[$];
  bit                           mid_q[$];

  dining_table dining_table_i (
    .clock(clock), .reset(reset), .cfg(cfg),
    .cfg_req(cfg_req), .cfg_ack(cfg_ack), .status(status)
  );

  dpp_checker checker_i (
    .clock(clock), .reset(reset), .cfg(cfg), .cfg_req(cfg_req), .cfg_ack(cfg_ack),
    .status(status), .exp_meals(exp_meals),
    .error_count(error_count), .dinner_count(dinner_count)
  );

  bind dinner_loader dpp_assert #(.W(1)) cfg_hs_assert (
    .clock(clock), .reset(reset), .req(cfg_req), .ack(cfg_ack)
  );
  bind fork_arbiter dpp_assert #(.W(`DPP_N_PHILO)) fork_hs_assert (
    .clock(clock), .reset(reset), .req(fork_req), .ack(fork_ack)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock; // 4 ns period
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: no result after %0d clock cycles", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic read_golden();
    int    fd;
    int    rc;
    int    mid;
    int    m[N];
    string line;
    logic [`DPP_DINNER_CFG_W-1:0] c;
    fd = $fopen("testbench/dpp_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/dpp_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        // comment lines do not parse and are skipped
        if (rc > 0 &&
            $sscanf(line, "%h %h %h %h %h %h", c, m[3], m[2], m[1], m[0], mid) == 6) begin
          cfg_q.push_back(c);
          exp_q.push_back({CW'(m[3]), CW'(m[2]), CW'(m[1]), CW'(m[0])});
          mid_q.push_back(mid != 0);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic offer_dinner(input int k); // call right after a rising edge
    cfg       <= cfg_q[k];
    exp_meals <= exp_q[k];
    cfg_req   <= 1'b1;
  endtask

  initial begin
    int gap;
    bit carried; // next request already raised during the last dinner
    reset     = 1'b1;
    cfg_req   = 1'b0;
    cfg       = '0;
    exp_meals = '0;
    carried   = 1'b0;
    gap       = $urandom(32'hec51e32c);
    read_golden();
    cycle_limit = 400 * cfg_q.size() + 20;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    for (int k = 0; k < cfg_q.size(); k++) begin
      if (!carried) begin
        gap = $urandom % 4;
        repeat (gap) @(posedge clock);
        @(posedge clock);
        offer_dinner(k);
      end
      do @(negedge clock); while (!cfg_ack);
      @(posedge clock);
      cfg_req <= 1'b0;
      do @(negedge clock); while (cfg_ack);
      carried = 1'b0;
      if (mid_q[k] && k + 1 < cfg_q.size()) begin
        @(posedge clock);
        offer_dinner(k + 1); // must wait for this dinner's done
        carried = 1'b1;
      end
      do @(negedge clock); while (!status.done);
    end
    repeat (4) @(posedge clock);
    $display("dinners checked: %0d of %0d, errors: %0d",
             dinner_count, cfg_q.size(), error_count);
    if (error_count == 0 && cfg_q.size() > 0 && dinner_count == cfg_q.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/dpp_pkg.sv
design/dinner_loader.sv
design/philosopher.sv
design/fork_arbiter.sv
design/dinner_tally.sv
design/dining_table.sv
testbench/dpp_assert.sv
testbench/dpp_checker.sv
testbench/tb_dining_table.sv
